// ==== load_pkg.sv ====
package load_pkg;

    // ******************************************************************
    // widths
    // ******************************************************************

    localparam int xlen = 32;  // rv32 data and address width.
    localparam int rob_tag_w = 6;  // reorder buffer tag width.

    // ******************************************************************
    // encodings
    // ******************************************************************

    typedef enum logic [6:0] {
        OP_LOAD = 7'b0000011,
        OP_IMM = 7'b0010011,
        OP_STORE = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_e;  // funct3[1:0] of a load.

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        WAIT_MEM = 2'b01,
        DONE = 2'b10
    } load_state_e;

    // ******************************************************************
    // packets
    // ******************************************************************

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e opcode;
    } inst_t;  // i-type view of the instruction word.

    typedef struct packed {
        logic issue_valid;
        inst_t inst;
        logic [xlen-1:0] rs1_value;
        logic [rob_tag_w-1:0] rob_tag;
    } fu_in_packet_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        mem_size_e size;
        logic is_unsigned;
        logic legal;  // opcode and funct3 name a real load.
        logic [rob_tag_w-1:0] rob_tag;
    } access_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        mem_size_e size;
    } mem_req_t;

    typedef struct packed {
        logic done;
        logic error;
        logic [rob_tag_w-1:0] rob_tag;
        logic [xlen-1:0] value;
    } fu_out_packet_t;

endpackage

// ==== load_decode.sv ====
module load_decode (
    input load_pkg::fu_in_packet_t fu_in,
    output load_pkg::access_t access
);

    import load_pkg::*;

    logic [xlen-1:0] imm_ext;
    logic funct3_ok;
    logic opcode_ok;

    // i-type immediate, sign bit is instruction bit 31.
    assign imm_ext = {{(xlen-12){fu_in.inst.imm[11]}}, fu_in.inst.imm};

    assign opcode_ok = (fu_in.inst.opcode == OP_LOAD);

    // lb, lh, lw, lbu and lhu are the only defined loads.
    always_comb begin
        case (fu_in.inst.funct3)
            3'd0, 3'd1, 3'd2, 3'd4, 3'd5: funct3_ok = 1'b1;
            default: funct3_ok = 1'b0;
        endcase
    end

    // ******************************************************************
    // access descriptor
    // ******************************************************************

    always_comb begin
        access.addr = fu_in.rs1_value + imm_ext;  // effective address.
        access.size = mem_size_e'(fu_in.inst.funct3[1:0]);
        access.is_unsigned = fu_in.inst.funct3[2];  // lbu and lhu.
        access.legal = opcode_ok && funct3_ok;
        access.rob_tag = fu_in.rob_tag;
    end

endmodule

// ==== load_unit.sv ====
module load_unit (
    input logic clock,
    input logic reset,
    input logic fu_in_valid,
    input load_pkg::access_t access,
    input logic result_ack,
    input logic mem_ack,
    input logic [31:0] ext_value,
    output logic mem_req,
    output load_pkg::mem_req_t mem_cmd,
    output logic [1:0] ext_lane,
    output load_pkg::mem_size_e ext_size,
    output logic ext_unsigned,
    output load_pkg::fu_out_packet_t fu_out,
    output logic busy
);

    import load_pkg::*;

    load_state_e state_q;
    access_t acc_q;  // access held for the whole transaction.

    // ******************************************************************
    // request and extension controls come from the held access
    // ******************************************************************

    assign mem_cmd.addr = acc_q.addr;
    assign mem_cmd.size = acc_q.size;
    assign ext_lane = acc_q.addr[1:0];
    assign ext_size = acc_q.size;
    assign ext_unsigned = acc_q.is_unsigned;

    assign busy = (state_q != IDLE);  // issues are only taken in idle.

    // payload of the access, loaded on an accepted issue.
    always_ff @(posedge clock) begin
        if (state_q == IDLE && fu_in_valid) begin
            acc_q <= access;
        end
    end

    // ******************************************************************
    // control state
    // ******************************************************************

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= IDLE;
            mem_req <= 1'b0;
            fu_out <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (fu_in_valid) begin
                        if (access.legal) begin
                            mem_req <= 1'b1;  // request goes out next cycle.
                            state_q <= WAIT_MEM;
                        end else begin
                            // not a load, complete at once with the error flag.
                            fu_out.done <= 1'b1;
                            fu_out.error <= 1'b1;
                            fu_out.rob_tag <= access.rob_tag;
                            fu_out.value <= '0;
                            state_q <= DONE;
                        end
                    end
                end
                WAIT_MEM: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        fu_out.done <= 1'b1;
                        fu_out.error <= 1'b0;
                        fu_out.rob_tag <= acc_q.rob_tag;
                        fu_out.value <= ext_value;  // word is valid with the ack.
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    // result is held here until the reorder buffer takes it.
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase

            // an acknowledge wins over every update above.
            if (result_ack) begin
                fu_out <= '0;
                mem_req <= 1'b0;
                state_q <= IDLE;
            end
        end
    end

endmodule

// ==== load_extend.sv ====
module load_extend (
    input logic [31:0] rdata,
    input logic [1:0] lane,
    input load_pkg::mem_size_e size,
    input logic is_unsigned,
    output logic [31:0] value
);

    import load_pkg::*;

    logic [7:0] byte_sel;
    logic [15:0] half_sel;

    // ******************************************************************
    // byte lane selection
    // ******************************************************************

    assign byte_sel = rdata[{lane, 3'b000} +: 8];  // one of four lanes.
    assign half_sel = lane[1] ? rdata[31:16] : rdata[15:0];  // upper or lower half.

    // ******************************************************************
    // extension
    // ******************************************************************

    always_comb begin
        case (size)
            BYTE: begin
                value = is_unsigned ? {24'd0, byte_sel} : {{24{byte_sel[7]}}, byte_sel};
            end
            HALF: begin
                value = is_unsigned ? {16'd0, half_sel} : {{16{half_sel[15]}}, half_sel};
            end
            default: begin
                value = rdata;  // a word needs no extension.
            end
        endcase
    end

endmodule

// ==== data_mem.sv ====
module data_mem #(
    parameter int DEPTH_WORDS = 256,
    parameter int MEM_LATENCY = 3
) (
    input logic clock,
    input logic reset,
    input logic mem_req,
    input load_pkg::mem_req_t mem_cmd,
    input logic wr_en,
    input logic [31:0] wr_addr,
    input logic [31:0] wr_data,
    output logic mem_ack,
    output logic [31:0] rdata
);

    import load_pkg::*;

    localparam int idx_w = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
    localparam int cnt_w = $clog2(MEM_LATENCY + 1);

    logic [xlen-1:0] mem [DEPTH_WORDS];
    logic [idx_w-1:0] rd_idx;
    logic [idx_w-1:0] wr_idx;
    logic [cnt_w-1:0] lat_cnt;
    logic counting;  // a request is being timed.
    logic served;  // ack given, waiting for the request to drop.

    // word index, wrapped to the memory depth.
    assign rd_idx = idx_w'(mem_cmd.addr[xlen-1:2] % DEPTH_WORDS);
    assign wr_idx = idx_w'(wr_addr[xlen-1:2] % DEPTH_WORDS);

    // preload port, whole words only.
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // ******************************************************************
    // fixed latency read
    // ******************************************************************

    always_ff @(posedge clock) begin
        if (reset) begin
            counting <= 1'b0;
            served <= 1'b0;
            lat_cnt <= '0;
            mem_ack <= 1'b0;
        end else begin
            mem_ack <= 1'b0;  // the ack is a single cycle pulse.
            if (!mem_req) begin
                counting <= 1'b0;
                served <= 1'b0;
            end else if (!counting && !served) begin
                counting <= 1'b1;  // first cycle that sees the request.
                lat_cnt <= cnt_w'(1);
            end else if (counting) begin
                if (lat_cnt == cnt_w'(MEM_LATENCY)) begin
                    counting <= 1'b0;
                    served <= 1'b1;
                    mem_ack <= 1'b1;
                end else begin
                    lat_cnt <= lat_cnt + 1'b1;
                end
            end
        end
    end

    // read word is presented together with the ack.
    always_ff @(posedge clock) begin
        if (counting && mem_req && lat_cnt == cnt_w'(MEM_LATENCY)) begin
            rdata <= mem[rd_idx];
        end
    end

endmodule

// ==== load_top.sv ====
module load_top #(
    parameter int DEPTH_WORDS = 256,
    parameter int MEM_LATENCY = 3
) (
    input logic clock,
    input logic reset,
    input load_pkg::fu_in_packet_t fu_in,
    input logic result_ack,
    input logic wr_en,
    input logic [31:0] wr_addr,
    input logic [31:0] wr_data,
    output load_pkg::fu_out_packet_t fu_out,
    output logic busy
);

    import load_pkg::*;

    access_t access;
    mem_req_t mem_cmd;
    logic mem_req;
    logic mem_ack;
    logic [xlen-1:0] rdata;
    logic [xlen-1:0] ext_value;
    logic [1:0] ext_lane;
    mem_size_e ext_size;
    logic ext_unsigned;

    // ******************************************************************
    // load path
    // ******************************************************************

    load_decode u_decode (
        .fu_in (fu_in),
        .access (access)
    );

    load_unit u_unit (
        .clock (clock),
        .reset (reset),
        .fu_in_valid (fu_in.issue_valid),
        .access (access),
        .result_ack (result_ack),
        .mem_ack (mem_ack),
        .ext_value (ext_value),
        .mem_req (mem_req),
        .mem_cmd (mem_cmd),
        .ext_lane (ext_lane),
        .ext_size (ext_size),
        .ext_unsigned (ext_unsigned),
        .fu_out (fu_out),
        .busy (busy)
    );

    load_extend u_extend (
        .rdata (rdata),
        .lane (ext_lane),
        .size (ext_size),
        .is_unsigned (ext_unsigned),
        .value (ext_value)
    );

    data_mem #(
        .DEPTH_WORDS (DEPTH_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem (
        .clock (clock),
        .reset (reset),
        .mem_req (mem_req),
        .mem_cmd (mem_cmd),
        .wr_en (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .mem_ack (mem_ack),
        .rdata (rdata)
    );

endmodule

// ==== load_props.sv ====
module load_props (
    input logic clock,
    input logic reset,
    input logic mem_req,
    input logic mem_ack,
    input logic result_ack,
    input load_pkg::fu_out_packet_t fu_out
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_cnt = 0;  // read by the testbench summary.

    // the request is dropped on the edge that sees the memory answer.
    req_drop: assert property (@(posedge clock) disable iff (reset)
        mem_ack |=> !mem_req)
    else begin
        $error("mem_req still high one cycle after mem_ack");
        fail_cnt++;
    end

    // a finished result waits for the reorder buffer.
    done_hold: assert property (@(posedge clock) disable iff (reset)
        fu_out.done && !result_ack |=> fu_out.done)
    else begin
        $error("fu_out.done dropped without result_ack");
        fail_cnt++;
    end

    // an illegal instruction never reaches the memory.
    no_req_on_error: assert property (@(posedge clock) disable iff (reset)
        !(mem_req && fu_out.error))
    else begin
        $error("mem_req high while the error flag is set");
        fail_cnt++;
    end

endmodule

bind load_unit load_props u_props (
    .clock (clock),
    .reset (reset),
    .mem_req (mem_req),
    .mem_ack (mem_ack),
    .result_ack (result_ack),
    .fu_out (fu_out)
);

// ==== tb_load_top.sv ====
module tb_load_top;
    timeunit 1ns;
    timeprecision 100ps;

    import load_pkg::*;

    localparam int latency = 3;
    localparam int depth = 256;
    localparam int n_loads = 52;  // loads issued over all tests.

    logic clock = 1'b0;
    logic reset;
    fu_in_packet_t fu_in;
    logic result_ack;
    logic wr_en;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    fu_out_packet_t fu_out;
    logic busy;

    logic [31:0] model [depth];  // copy of what was written through the preload port.
    logic [31:0] lfsr_q = 32'h4e26_1931;
    string test_name;
    int test_err;
    int passed = 0;
    int failed = 0;

    load_top #(.DEPTH_WORDS(depth), .MEM_LATENCY(latency)) DUT (
        .clock (clock),
        .reset (reset),
        .fu_in (fu_in),
        .result_ack (result_ack),
        .wr_en (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .fu_out (fu_out),
        .busy (busy)
    );

    always #2 clock = ~clock;

    // **********************************************************************
    // helpers
    // **********************************************************************

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic inst_t make_inst(input logic [11:0] imm, input logic [2:0] f3,
                                        input opcode_e op);
        inst_t inst;
        inst.imm = imm;
        inst.rs1 = 5'(rand_bits(5));
        inst.funct3 = f3;
        inst.rd = 5'(rand_bits(5));
        inst.opcode = op;
        return inst;
    endfunction

    function automatic logic is_legal(input opcode_e op, input logic [2:0] f3);
        return op == OP_LOAD && f3 != 3'd3 && f3 < 3'd6;  // lb lh lw lbu lhu.
    endfunction

    // expected load result from the word, the low address bits and funct3.
    function automatic logic [31:0] expect_load(input logic [31:0] word, input logic [1:0] low,
                                                input logic [2:0] f3);
        logic [31:0] b;
        logic [31:0] h;
        b = word >> (8 * low);
        h = word >> (16 * low[1]);  // halves are picked by address bit 1.
        case (f3)
            3'd0: return 32'(signed'(b[7:0]));
            3'd1: return 32'(signed'(h[15:0]));
            3'd4: return 32'(b[7:0]);
            3'd5: return 32'(h[15:0]);
            default: return word;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
            test_err++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond === 1'b1) else begin
            $display("%s: %s", test_name, msg);
            test_err++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err = 0;
    endtask

    task automatic finish_test();
        if (test_err == 0) begin
            passed++;
            $display("test %s finished without errors", test_name);
        end else begin
            failed++;
            $display("test %s finished with %0d errors", test_name, test_err);
        end
    endtask

    // issues one instruction, checks the completion, holds it for hold cycles, then acks.
    task automatic run_load(input opcode_e op, input logic [2:0] f3, input logic [31:0] rs1,
                            input logic [11:0] imm, input int hold);
        logic [31:0] addr;
        logic legal;
        logic [31:0] exp_value;
        logic [5:0] tag;
        int cycles;
        fu_out_packet_t held;
        addr = rs1 + {{20{imm[11]}}, imm};
        legal = is_legal(op, f3);
        exp_value = legal ? expect_load(model[addr[9:2]], addr[1:0], f3) : 32'd0;
        tag = 6'(rand_bits(6));
        @(negedge clock);
        fu_in.issue_valid = 1'b1;
        fu_in.inst = make_inst(imm, f3, op);
        fu_in.rs1_value = rs1;
        fu_in.rob_tag = tag;
        @(negedge clock);
        fu_in = '0;
        cycles = 0;  // edges after the issue edge.
        while (!fu_out.done) begin
            check_true(busy, "busy dropped while a load was pending");
            @(negedge clock);
            cycles++;
        end
        check_value("issue to done cycles", legal ? 32'(latency + 2) : 32'd0, 32'(cycles));
        check_value("error", 32'(!legal), 32'(fu_out.error));
        check_value("rob_tag", 32'(tag), 32'(fu_out.rob_tag));
        check_value("value", exp_value, fu_out.value);
        check_true(legal || !DUT.mem_req, "memory request made for an illegal instruction");
        held = fu_out;
        repeat (hold) begin
            @(negedge clock);
            check_true(fu_out == held, "fu_out changed before the result was acknowledged");
            check_true(busy, "busy dropped while the result was held");
        end
        result_ack = 1'b1;
        @(negedge clock);
        result_ack = 1'b0;
        check_true(fu_out == '0, "fu_out not cleared one cycle after result_ack");
        check_true(!busy, "unit still busy one cycle after result_ack");
    endtask

    // **********************************************************************
    // tests
    // **********************************************************************

    task automatic test_word();
        start_test("word_loads");
        for (int i = 0; i < 16; i++) begin
            run_load(OP_LOAD, 3'd2, rand_bits(30) << 2, 12'(rand_bits(10) << 2), 0);
        end
        finish_test();
    endtask

    task automatic test_byte_half();
        logic [2:0] f3;
        start_test("byte_half_loads");
        for (int k = 0; k < 4; k++) begin
            f3 = 3'((k / 2) * 4 + (k % 2));  // 0, 1, 4 and 5.
            for (int lane = 0; lane < 4; lane++) begin
                run_load(OP_LOAD, f3, (rand_bits(30) << 2) | 32'(lane),
                         12'(rand_bits(10) << 2), 0);
            end
        end
        finish_test();
    endtask

    task automatic test_neg_imm();
        start_test("negative_immediates");
        for (int i = 0; i < 4; i++) begin
            run_load(OP_LOAD, 3'd2, rand_bits(30) << 2, 12'(-4 * (i + 1)), 0);
        end
        finish_test();
    endtask

    task automatic test_latency();
        start_test("fixed_latency");
        for (int i = 0; i < 4; i++) begin
            run_load(OP_LOAD, 3'd2, 32'(i * 4), 12'd0, 1);
        end
        finish_test();
    endtask

    task automatic test_illegal();
        start_test("illegal_instructions");
        run_load(OP_LOAD, 3'd3, rand_bits(32), 12'd0, 1);
        run_load(OP_LOAD, 3'd6, rand_bits(32), 12'd0, 1);
        run_load(OP_LOAD, 3'd7, rand_bits(32), 12'd0, 1);
        run_load(OP_IMM, 3'd2, rand_bits(32), 12'd0, 1);
        run_load(OP_STORE, 3'd2, rand_bits(32), 12'd0, 1);
        run_load(OP_BRANCH, 3'd0, rand_bits(32), 12'd0, 1);
        finish_test();
    endtask

    task automatic test_backpressure();
        start_test("back_pressure");
        for (int i = 0; i < 6; i++) begin
            run_load(OP_LOAD, (i % 2) ? 3'd4 : 3'd2, rand_bits(30) << 2, 12'd0,
                     int'(rand_bits(4)));
        end
        finish_test();
    endtask

    // **********************************************************************
    // main sequence and watchdog
    // **********************************************************************

    initial begin
        reset = 1'b1;
        fu_in = '0;
        result_ack = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < depth; i++) begin
            @(negedge clock);
            wr_en = 1'b1;
            wr_addr = 32'(i) << 2;
            wr_data = rand_bits(32);
            model[i] = wr_data;
        end
        @(negedge clock);
        wr_en = 1'b0;
        test_word();
        test_byte_half();
        test_neg_imm();
        test_latency();
        test_illegal();
        test_backpressure();
        $display("summary: %0d tests passed, %0d tests failed, %0d assertion failures",
                 passed, failed, DUT.u_unit.u_props.fail_cnt);
        if (failed == 0 && DUT.u_unit.u_props.fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        repeat (depth + 10 + n_loads * 40) @(posedge clock);  // preload, reset, loads.
        $display("watchdog expired before all tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== tb.f ====
load_pkg.sv
load_decode.sv
load_unit.sv
load_extend.sv
data_mem.sv
load_top.sv
load_props.sv
tb_load_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= tb_load_top
FILELIST ?= tb.f
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
